/* list.f */
common/boot_pkg.sv
common/axi_lite_pkg.sv
axi/axi_lite_master.sv
source/byte_fetch.sv
source/word_fifo.sv
source/imem_loader.sv
source/boot.sv
sim/boot_tb.sv

/* Makefile */
# Verilator build and run of the boot loader testbench

TOP ?= boot_tb
FILE_LIST ?= list.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VERILATOR ?= verilator
VFLAGS ?= --binary --timing --assert -Wno-fatal
PASS_TEXT ?= all tests passed

SRCS := $(filter-out +%,$(shell cat $(FILE_LIST)))

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, and search $(LOG) for the pass message"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

$(BUILD_DIR)/V$(TOP): $(SRCS) $(FILE_LIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILE_LIST)

test: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -qx "$(PASS_TEXT)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* sim/boot_tb.sv */
`timescale 1ns/10ps
`default_nettype none

module boot_tb;
    import boot_pkg::*;
    import axi_lite_pkg::*;

    localparam int INSTR_ADDRW = 10;
    localparam int N_WORDS = 9;
    localparam int ERR_READ = 21; // read answered with SLVERR in the second run
    localparam int TXN_PER_RUN = 2 + 2 * (4 + 4 * N_WORDS); // room for empty polls
    localparam int WATCHDOG_NS = 2 * TXN_PER_RUN * 200 * 40;

    logic clk = 1'b0;
    logic reset = 1'b1;
    axi_ar_t ar;
    logic arvalid;
    logic arready = 1'b0;
    axi_r_t r = '0;
    logic rvalid = 1'b0;
    logic rready;
    axi_aw_t aw;
    logic awvalid;
    logic awready = 1'b0;
    axi_w_t w;
    logic wvalid;
    logic wready = 1'b0;
    axi_b_t b = '0; // always OKAY
    logic bvalid = 1'b0;
    logic bready;
    logic instr_we;
    logic [INSTR_ADDRW-1:0] instr_addr;
    word_t instr_data;
    logic core_clk_en;
    logic boot_error;

    logic [31:0] seed = 32'h2160_21bb;
    word_t prog [N_WORDS];
    word_t shadow [2 ** INSTR_ADDRW];
    byte_t rx_q [$];
    byte_t tx_log [$];
    byte_t rx_byte;
    logic inject_err = 1'b0;
    logic ar_fire, r_fire, aw_fire, w_fire, b_fire;
    logic aw_seen, w_seen, rd_owed, b_owed;
    int reads, writes, bytes_sent, empty_polls, we_count;
    int words_before_error; // complete words delivered ahead of the SLVERR
    int errors, errors_seen, tests_failed;

    boot #(.INSTR_ADDRW(INSTR_ADDRW), .FIFO_ADDRW(4)) boot_inst (.*);

    always #20 clk = ~clk;

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic note_error(input string msg);
        errors++;
        $display("error at t=%0t: %s", $time, msg);
    endtask

    task automatic value_error(input string name, input logic [31:0] exp, input logic [31:0] act);
        errors++;
        $display("FAIL t=%0t %s expected %h got %h", $time, name, exp, act);
    endtask

    task automatic report_test(input int num, input string name);
        if (errors == errors_seen) begin
            $display("test %0d %s: ok", num, name);
        end else begin
            $display("test %0d %s: FAILED with %0d errors", num, name, errors - errors_seen);
            tests_failed++;
        end
        errors_seen = errors;
    endtask

    // called on a falling edge and returns with reset released
    task automatic start_run(input logic inject);
        reset = 1'b1;
        inject_err = inject;
        reads = 0;
        writes = 0;
        bytes_sent = 0;
        empty_polls = 0;
        we_count = 0;
        rx_q.delete();
        tx_log.delete();
        for (int k = 0; k < 4; k++) rx_q.push_back(byte_t'(N_WORDS >> (8 * k))); // count header
        for (int i = 0; i < N_WORDS; i++) begin
            for (int k = 0; k < 4; k++) rx_q.push_back(prog[i][8 * k +: 8]);
        end
        repeat (2) @(negedge clk);
        assert ({arvalid, awvalid, wvalid, rready, bready, instr_we, core_clk_en, boot_error,
                 boot_inst.link_up} == '0)
            else note_error("control outputs not all low during reset");
        reset = 1'b0;
    endtask

    // handshakes seen at the rising edge and used by the driver on the next falling edge
    always @(posedge clk) begin
        ar_fire = arvalid && arready;
        r_fire = rvalid && rready;
        aw_fire = awvalid && awready;
        w_fire = wvalid && wready;
        b_fire = bvalid && bready;
        if (!reset) begin
            if (ar_fire) begin
                reads++;
                rd_owed = 1'b1;
                assert (writes >= 1) else note_error("read issued before the hello write finished");
                assert (ar.addr == RX_ADDR) else value_error("ar.addr", RX_ADDR, ar.addr);
            end
            if (aw_fire) begin
                aw_seen = 1'b1;
                assert (aw.addr == TX_ADDR) else value_error("aw.addr", TX_ADDR, aw.addr);
            end
            if (w_fire) begin
                w_seen = 1'b1;
                tx_log.push_back(w.data[7:0]);
                assert (w.strb == 4'b0001) else value_error("w.strb", 4'b0001, w.strb);
            end
            if (aw_seen && w_seen) begin
                b_owed = 1'b1;
                aw_seen = 1'b0;
                w_seen = 1'b0;
            end
            if (b_fire) writes++;
            if (instr_we) begin
                we_count++;
                shadow[instr_addr] = instr_data;
                assert (instr_addr < N_WORDS) else note_error("instr_we outside the program range");
            end
        end
    end

    // peripheral model with random ready and valid delays
    always @(negedge clk) begin
        seed = xorshift(seed);
        if (reset) begin
            arready <= 1'b0;
            awready <= 1'b0;
            wready <= 1'b0;
            rvalid <= 1'b0;
            bvalid <= 1'b0;
            rd_owed = 1'b0;
            b_owed = 1'b0;
            aw_seen = 1'b0;
            w_seen = 1'b0;
        end else begin
            arready <= arvalid && seed[0];
            awready <= awvalid && seed[1];
            wready <= wvalid && seed[2];
            if (r_fire) begin
                rvalid <= 1'b0;
            end else if (rd_owed && !rvalid && seed[3]) begin
                rvalid <= 1'b1;
                rd_owed = 1'b0;
                if (inject_err && reads == ERR_READ) begin
                    r <= '{data: 32'h0, resp: 2'b10};
                end else if (rx_q.size() == 0 || seed[6:5] == 2'b00) begin
                    r <= '{data: 32'h0, resp: RESP_OKAY}; // nothing received yet
                    empty_polls++;
                end else begin
                    rx_byte = rx_q.pop_front();
                    r <= '{data: {23'h0, 1'b1, rx_byte}, resp: RESP_OKAY};
                    bytes_sent++;
                end
            end
            if (b_fire) begin
                bvalid <= 1'b0;
            end else if (b_owed && !bvalid && seed[4]) begin
                bvalid <= 1'b1;
                b_owed = 1'b0;
            end
        end
    end

    a_run_held: assert property (@(posedge clk) disable iff (reset) core_clk_en |=> core_clk_en)
        else note_error("core_clk_en dropped after the core was enabled");
    a_run_quiet: assert property (@(posedge clk) disable iff (reset)
        core_clk_en |-> !arvalid && !awvalid && !instr_we)
        else note_error("bus or memory traffic after the core was enabled");
    a_err_held: assert property (@(posedge clk) disable iff (reset) boot_error |=> boot_error)
        else note_error("boot_error dropped without a reset");
    a_err_quiet: assert property (@(posedge clk) disable iff (reset)
        boot_error |-> !core_clk_en && !arvalid && !awvalid)
        else note_error("core enabled or bus traffic after boot_error");

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired before the boot sequence finished");
        $display("tests failed");
        $finish;
    end

    initial begin
        for (int i = 0; i < N_WORDS; i++) begin
            seed = xorshift(seed);
            prog[i] = seed;
        end
        start_run(1'b0);
        while (!core_clk_en) @(negedge clk);
        repeat (40) @(negedge clk); // core must stay enabled and the bus quiet
        assert (tx_log[0] == HELLO_BYTE) else value_error("first tx byte", HELLO_BYTE, tx_log[0]);
        report_test(1, "reset state and hello write");
        assert (we_count == N_WORDS) else value_error("instr_we count", N_WORDS, we_count);
        for (int i = 0; i < N_WORDS; i++) begin
            assert (shadow[i] == prog[i])
                else value_error($sformatf("instr_mem[%0d]", i), prog[i], shadow[i]);
        end
        report_test(2, "program load");
        assert (bytes_sent == 4 + 4 * N_WORDS && rx_q.size() == 0)
            else value_error("bytes delivered", 4 + 4 * N_WORDS, bytes_sent);
        assert (empty_polls > 0) else note_error("no empty poll was served");
        report_test(3, "empty polls and slow ready");
        assert (tx_log.size() == 2) else value_error("tx byte count", 2, tx_log.size());
        assert (tx_log[1] == DONE_BYTE) else value_error("last tx byte", DONE_BYTE, tx_log[1]);
        assert (core_clk_en) else note_error("core_clk_en is not high at the end of the load");
        report_test(4, "done write and core enable");

        start_run(1'b1);
        while (!boot_error) @(negedge clk);
        repeat (40) @(negedge clk);
        assert (reads == ERR_READ) else value_error("read count", ERR_READ, reads);
        assert (tx_log.size() == 1) else value_error("tx byte count", 1, tx_log.size());
        words_before_error = (bytes_sent < 4) ? 0 : (bytes_sent - 4) / 4;
        assert (we_count == words_before_error)
            else value_error("instr_we count", words_before_error, we_count);
        assert (boot_error && !core_clk_en) else note_error("wrong state after SLVERR");
        report_test(5, "read error response");

        $display("5 tests run, %0d failed, %0d errors", tests_failed, errors);
        if (errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* source/boot.sv */
`timescale 1ns/10ps
`default_nettype none

module boot #(
    parameter int INSTR_ADDRW = 10,
    parameter int FIFO_ADDRW = 4
) (
    input logic clk, reset,

    output axi_lite_pkg::axi_ar_t ar,
    output logic arvalid,
    input logic arready,
    input axi_lite_pkg::axi_r_t r,
    input logic rvalid,
    output logic rready,

    output axi_lite_pkg::axi_aw_t aw,
    output logic awvalid,
    input logic awready,
    output axi_lite_pkg::axi_w_t w,
    output logic wvalid,
    input logic wready,
    input axi_lite_pkg::axi_b_t b,
    input logic bvalid,
    output logic bready,

    output logic instr_we,
    output logic [INSTR_ADDRW-1:0] instr_addr,
    output boot_pkg::word_t instr_data,

    output logic core_clk_en,
    output logic boot_error
);
    import boot_pkg::*;
    import axi_lite_pkg::*;

    // master request side
    logic rd_req;
    logic rd_done;
    axi_data_t rd_data;
    axi_resp_t rd_resp;
    logic wr_req;
    byte_t wr_byte;
    logic wr_done;
    axi_resp_t wr_resp;

    logic link_up;

    // fifo
    logic push;
    boot_word_t push_data;
    logic pop;
    boot_word_t head;
    logic full;
    logic empty;

    axi_lite_master axi_lite_master_inst (.*);

    byte_fetch byte_fetch_inst (.*);

    word_fifo #(
        .FIFO_ADDRW(FIFO_ADDRW)
    ) word_fifo_inst (.*);

    imem_loader #(
        .INSTR_ADDRW(INSTR_ADDRW)
    ) imem_loader_inst (.*);

endmodule

`default_nettype wire

/* source/imem_loader.sv */
`timescale 1ns/10ps
`default_nettype none

module imem_loader #(
    parameter int INSTR_ADDRW = 10
) (
    input logic clk, reset,
    output logic link_up,

    output logic wr_req,
    output boot_pkg::byte_t wr_byte,
    input logic wr_done,
    input axi_lite_pkg::axi_resp_t wr_resp,

    input logic rd_done,
    input axi_lite_pkg::axi_resp_t rd_resp,

    input logic empty,
    input boot_pkg::boot_word_t head,
    output logic pop,

    output logic instr_we,
    output logic [INSTR_ADDRW-1:0] instr_addr,
    output boot_pkg::word_t instr_data,

    output logic core_clk_en,
    output logic boot_error
);
    import boot_pkg::*;
    import axi_lite_pkg::*;

    typedef enum logic [2:0] {HELLO, LOAD, DONE, RUN, ERROR} state_t;

    state_t state;
    logic bad_resp;

    assign bad_resp = (rd_done && rd_resp != RESP_OKAY) || (wr_done && wr_resp != RESP_OKAY);

    assign wr_req = (state == HELLO) || (state == DONE);
    assign wr_byte = (state == DONE) ? DONE_BYTE : HELLO_BYTE;
    assign link_up = (state == LOAD) || (state == DONE) || (state == RUN);

    assign pop = (state == LOAD) && !empty;
    assign instr_we = pop; // one memory write per popped word
    assign instr_data = head.data;

    assign core_clk_en = (state == RUN);
    assign boot_error = (state == ERROR);

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= HELLO;
            instr_addr <= '0;
        end else begin
            if (pop) instr_addr <= instr_addr + 1'b1;
            if (bad_resp) begin
                state <= ERROR; // sticky, no way out but reset
            end else begin
                case (state)
                    HELLO: if (wr_done) state <= LOAD;
                    LOAD: if (pop && head.last) state <= DONE;
                    DONE: if (wr_done) state <= RUN;
                    default: state <= state;
                endcase
            end
        end
    end

    // program larger than the instruction memory
    a_addr_no_wrap: assert property (@(posedge clk) disable iff (reset)
        instr_we |=> instr_addr != '0);

endmodule

`default_nettype wire

/* source/word_fifo.sv */
`timescale 1ns/10ps
`default_nettype none

module word_fifo #(
    parameter int FIFO_ADDRW = 4
) (
    input logic clk, reset,

    input logic push,
    input boot_pkg::boot_word_t push_data,

    input logic pop,
    output boot_pkg::boot_word_t head,

    output logic full,
    output logic empty
);
    import boot_pkg::*;

    localparam int DEPTH = 2 ** FIFO_ADDRW;

    boot_word_t mem [DEPTH];
    logic [FIFO_ADDRW-1:0] wr_ptr;
    logic [FIFO_ADDRW-1:0] rd_ptr;
    logic [FIFO_ADDRW:0] count;

    assign head = mem[rd_ptr]; // fall-through, no read latency
    assign empty = (count == '0);
    assign full = (count == (FIFO_ADDRW + 1)'(DEPTH));

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end else begin
            if (push) wr_ptr <= wr_ptr + 1'b1;
            if (pop) rd_ptr <= rd_ptr + 1'b1;
            count <= count + (push ? 1'b1 : 1'b0) - (pop ? 1'b1 : 1'b0);
        end
    end

    always_ff @(posedge clk) begin
        if (push) mem[wr_ptr] <= push_data;
    end

    a_no_overflow: assert property (@(posedge clk) disable iff (reset) full |-> !push);
    a_no_underflow: assert property (@(posedge clk) disable iff (reset) empty |-> !pop);

endmodule

`default_nettype wire

/* source/byte_fetch.sv */
`timescale 1ns/10ps
`default_nettype none

module byte_fetch (
    input logic clk, reset,
    input logic link_up,

    output logic rd_req,
    input logic rd_done,
    input axi_lite_pkg::axi_data_t rd_data,

    input logic full,
    output logic push,
    output boot_pkg::boot_word_t push_data
);
    import boot_pkg::*;

    logic [1:0] byte_cnt;
    logic have_count; // header word already taken
    logic finished;   // last word pushed, polling stops
    logic take;
    word_t word_q;
    word_t next_word;
    word_t remaining;

    assign take = rd_done && rd_data[RX_VALID_BIT]; // empty polls are dropped
    assign next_word = {rd_data[7:0], word_q[31:8]}; // little-endian shift

    assign push_data.data = word_q;
    assign push_data.last = (remaining == 32'd1);

    always_ff @(posedge clk) begin
        if (reset) begin
            rd_req <= 1'b0;
            push <= 1'b0;
            byte_cnt <= 2'd0;
            have_count <= 1'b0;
            finished <= 1'b0;
        end else begin
            push <= 1'b0;
            if (rd_done) begin
                rd_req <= 1'b0;
            end else if (!rd_req && link_up && !full && !push && !finished) begin
                rd_req <= 1'b1; // held until rd_done
            end
            if (take) begin
                byte_cnt <= byte_cnt + 2'd1;
                if (byte_cnt == 2'd3) begin
                    if (have_count) begin
                        push <= 1'b1;
                    end else begin
                        have_count <= 1'b1;
                    end
                end
            end
            if (push && push_data.last) finished <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (take) word_q <= next_word;
        if (take && byte_cnt == 2'd3 && !have_count) begin
            remaining <= next_word; // word count N
        end else if (push) begin
            remaining <= remaining - 32'd1;
        end
    end

    // an empty program would never raise last
    a_count_nonzero: assert property (@(posedge clk) disable iff (reset)
        have_count && !$past(have_count) |-> remaining != '0);

endmodule

`default_nettype wire

/* axi/axi_lite_master.sv */
`timescale 1ns/10ps
`default_nettype none

module axi_lite_master (
    input logic clk, reset,

    input logic rd_req,
    output logic rd_done,
    output axi_lite_pkg::axi_data_t rd_data,
    output axi_lite_pkg::axi_resp_t rd_resp,

    input logic wr_req,
    input boot_pkg::byte_t wr_byte,
    output logic wr_done,
    output axi_lite_pkg::axi_resp_t wr_resp,

    output axi_lite_pkg::axi_ar_t ar,
    output logic arvalid,
    input logic arready,
    input axi_lite_pkg::axi_r_t r,
    input logic rvalid,
    output logic rready,

    output axi_lite_pkg::axi_aw_t aw,
    output logic awvalid,
    input logic awready,
    output axi_lite_pkg::axi_w_t w,
    output logic wvalid,
    input logic wready,
    input axi_lite_pkg::axi_b_t b,
    input logic bvalid,
    output logic bready
);
    import boot_pkg::*;

    typedef enum logic [2:0] {IDLE, RD_ADDR, RD_DATA, RD_DONE, WR_SEND, WR_RESP, WR_DONE} state_t;

    state_t state;
    byte_t wr_byte_q;

    assign ar = '{addr: RX_ADDR, prot: 3'b000};
    assign aw = '{addr: TX_ADDR, prot: 3'b000};
    assign w = '{data: {24'h0, wr_byte_q}, strb: 4'b0001}; // single byte lane

    assign arvalid = (state == RD_ADDR);
    assign rready = (state == RD_DATA);
    assign rd_done = (state == RD_DONE);
    assign bready = (state == WR_RESP);
    assign wr_done = (state == WR_DONE);

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= IDLE;
            awvalid <= 1'b0;
            wvalid <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    if (rd_req) begin
                        state <= RD_ADDR;
                    end else if (wr_req) begin
                        state <= WR_SEND;
                        awvalid <= 1'b1; // aw and w go out together
                        wvalid <= 1'b1;
                    end
                end
                RD_ADDR: if (arready) state <= RD_DATA;
                RD_DATA: if (rvalid) state <= RD_DONE;
                WR_SEND: begin
                    if (awready) awvalid <= 1'b0;
                    if (wready) wvalid <= 1'b0;
                    if ((awready || !awvalid) && (wready || !wvalid)) state <= WR_RESP;
                end
                WR_RESP: if (bvalid) state <= WR_DONE;
                default: state <= IDLE; // done pulses last one cycle
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == IDLE) wr_byte_q <= wr_byte;
        if (rvalid && rready) begin
            rd_data <= r.data;
            rd_resp <= r.resp;
        end
        if (bvalid && bready) wr_resp <= b.resp;
    end

    a_ar_hold: assert property (@(posedge clk) disable iff (reset)
        arvalid && !arready |=> arvalid);
    a_aw_hold: assert property (@(posedge clk) disable iff (reset)
        awvalid && !awready |=> awvalid);
    a_w_hold: assert property (@(posedge clk) disable iff (reset)
        wvalid && !wready |=> wvalid && $stable(w));

endmodule

`default_nettype wire

/* common/axi_lite_pkg.sv */
`default_nettype none

package axi_lite_pkg;

    typedef logic [31:0] axi_addr_t;
    typedef logic [31:0] axi_data_t;
    typedef logic [1:0] axi_resp_t;

    localparam axi_resp_t RESP_OKAY = 2'b00;

    typedef struct packed {
        axi_addr_t addr;
        logic [2:0] prot;
    } axi_ar_t;

    typedef struct packed {
        axi_addr_t addr;
        logic [2:0] prot;
    } axi_aw_t;

    typedef struct packed {
        axi_data_t data;
        logic [3:0] strb;
    } axi_w_t;

    typedef struct packed {
        axi_data_t data;
        axi_resp_t resp;
    } axi_r_t;

    typedef struct packed {
        axi_resp_t resp;
    } axi_b_t;

endpackage

`default_nettype wire

/* common/boot_pkg.sv */
`default_nettype none

package boot_pkg;

    typedef logic [31:0] word_t;
    typedef logic [7:0] byte_t;

    // one FIFO entry, program word plus end-of-program mark
    typedef struct packed {
        word_t data;
        logic last;
    } boot_word_t;

    // peripheral register map
    localparam logic [31:0] RX_ADDR = 32'h0;
    localparam logic [31:0] TX_ADDR = 32'h4;

    localparam byte_t HELLO_BYTE = 8'h99; // sent before polling starts
    localparam byte_t DONE_BYTE = 8'haa;  // sent after the last word

    localparam int RX_VALID_BIT = 8; // byte-present flag in rx data

endpackage

`default_nettype wire
